//--- sm83_pkg.sv
package sm83_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;

    // Codes 0 to 7 match the opcode register fields, 6 is the [HL] slot
    typedef enum logic [3:0] {
        R_B = 4'd0,
        R_C = 4'd1,
        R_D = 4'd2,
        R_E = 4'd3,
        R_H = 4'd4,
        R_L = 4'd5,
        R_A = 4'd7,
        R_Z = 4'd8
    } r8_t;

    // Same order as opcode bits 5:4
    typedef enum logic [1:0] {RR_BC, RR_DE, RR_HL, RR_SP} rr_t;

    typedef enum logic [1:0] {BUS_IDLE, BUS_FETCH, BUS_READ, BUS_WRITE} bus_op_t;

    // First eight codes equal opcode bits 5:3 of the 8-bit ALU group
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        ADC  = 4'd1,
        SUB  = 4'd2,
        SBC  = 4'd3,
        AND  = 4'd4,
        XOR  = 4'd5,
        OR   = 4'd6,
        CP   = 4'd7,
        INC  = 4'd8,
        DEC  = 4'd9,
        PASS = 4'd10
    } alu_op_t;

    typedef enum logic {SRC_A_ACC, SRC_A_REG} alu_src_a_t;
    typedef enum logic {SRC_B_REG, SRC_B_ONE} alu_src_b_t;
    typedef enum logic {WR_FROM_ALU, WR_FROM_BUS} wr_src_t;
    typedef enum logic {ADDR_PC, ADDR_HL} addr_sel_t;
    typedef enum logic [1:0] {MC_1, MC_2, MC_3} mcycle_t;

    typedef struct packed {
        r8_t       rd_sel;
        logic      wr_en;
        r8_t       wr_sel;
        wr_src_t   wr_src;
        logic      rr_load_z;   // Pair gets {bus, Z}
        rr_t       rr_sel;
        logic      idu_en;
        logic      idu_dec;
        logic      idu_on_pc;   // Step PC instead of rr_sel
        addr_sel_t addr_sel;
    } rf_ctrl_t;

    typedef struct packed {
        logic       en;
        alu_op_t    op;
        alu_src_a_t src_a;
        alu_src_b_t src_b;
    } alu_ctrl_t;

    typedef struct packed {
        bus_op_t op;
        addr_t   addr;
        byte_t   wdata;
    } bus_req_t;

endpackage

//--- sm83_control.sv
`timescale 1ns/10ps

module sm83_control (
    input  logic                 clk,
    input  logic                 rst,
    input  sm83_pkg::byte_t      mem_rdata,
    output sm83_pkg::rf_ctrl_t   rf_ctrl,
    output sm83_pkg::alu_ctrl_t  alu_ctrl,
    output sm83_pkg::bus_op_t    bus_op
);
    import sm83_pkg::*;

    // Instruction groups that the core executes
    typedef enum logic [3:0] {
        I_NOP,
        I_LD_R,
        I_LD_R_N,
        I_LD_R_HL,
        I_LD_HL_R,
        I_LD_HL_N,
        I_LD_RR,
        I_INCDEC_R,
        I_INCDEC_RR,
        I_ALU_R,
        I_ALU_HL,
        I_ALU_N
    } instr_t;

    byte_t   opcode;
    mcycle_t mcycle;
    mcycle_t mcycle_next;
    instr_t  cls;
    r8_t     dst;
    r8_t     src;
    alu_op_t grp_op;

    assign dst    = r8_t'({1'b0, opcode[5:3]});
    assign src    = r8_t'({1'b0, opcode[2:0]});
    assign grp_op = alu_op_t'({1'b0, opcode[5:3]});

    // Decode by bit fields, anything else runs as NOP
    always_comb begin
        cls = I_NOP;
        case (opcode[7:6])
            2'b00: begin
                if (opcode[3:0] == 4'b0001)
                    cls = I_LD_RR;
                else if (opcode[2:0] == 3'b011)
                    cls = I_INCDEC_RR;
                else if (opcode[2:1] == 2'b10 && opcode[5:3] != 3'b110)
                    cls = I_INCDEC_R;
                else if (opcode[2:0] == 3'b110)
                    cls = (opcode[5:3] == 3'b110) ? I_LD_HL_N : I_LD_R_N;
            end
            2'b01: begin
                // 0x76 would be HALT
                if (opcode == 8'h76)
                    cls = I_NOP;
                else if (opcode[2:0] == 3'b110)
                    cls = I_LD_R_HL;
                else if (opcode[5:3] == 3'b110)
                    cls = I_LD_HL_R;
                else
                    cls = I_LD_R;
            end
            2'b10: cls = (opcode[2:0] == 3'b110) ? I_ALU_HL : I_ALU_R;
            default: begin
                if (opcode[2:0] == 3'b110)
                    cls = I_ALU_N;
            end
        endcase
    end

    always_comb begin
        bus_op      = BUS_IDLE;
        mcycle_next = MC_1;
        rf_ctrl     = '{rd_sel: R_A, wr_en: 1'b0, wr_sel: R_A, wr_src: WR_FROM_ALU,
                        rr_load_z: 1'b0, rr_sel: RR_BC, idu_en: 1'b0, idu_dec: 1'b0,
                        idu_on_pc: 1'b0, addr_sel: ADDR_PC};
        alu_ctrl    = '{en: 1'b0, op: PASS, src_a: SRC_A_REG, src_b: SRC_B_REG};

        if (!rst) begin
            // Default cycle fetches the next opcode and steps PC
            bus_op            = BUS_FETCH;
            rf_ctrl.idu_en    = 1'b1;
            rf_ctrl.idu_on_pc = 1'b1;

            case (cls)
                I_LD_R: begin
                    alu_ctrl       = '{en: 1'b1, op: PASS, src_a: SRC_A_REG, src_b: SRC_B_REG};
                    rf_ctrl.rd_sel = src;
                    rf_ctrl.wr_en  = 1'b1;
                    rf_ctrl.wr_sel = dst;
                end
                I_INCDEC_R: begin
                    alu_ctrl.en    = 1'b1;
                    alu_ctrl.op    = opcode[0] ? DEC : INC;
                    alu_ctrl.src_b = SRC_B_ONE;
                    rf_ctrl.rd_sel = dst;
                    rf_ctrl.wr_en  = 1'b1;
                    rf_ctrl.wr_sel = dst;
                end
                I_LD_R_N, I_LD_R_HL: begin
                    if (mcycle == MC_1) begin
                        bus_op         = BUS_READ;
                        rf_ctrl.wr_en  = 1'b1;
                        rf_ctrl.wr_sel = dst;
                        rf_ctrl.wr_src = WR_FROM_BUS;
                        mcycle_next    = MC_2;
                        if (cls == I_LD_R_HL) begin
                            rf_ctrl.addr_sel = ADDR_HL;
                            rf_ctrl.idu_en   = 1'b0;
                        end
                    end
                end
                I_LD_HL_R: begin
                    if (mcycle == MC_1) begin
                        bus_op           = BUS_WRITE;
                        rf_ctrl.rd_sel   = src;
                        rf_ctrl.addr_sel = ADDR_HL;
                        rf_ctrl.idu_en   = 1'b0;
                        mcycle_next      = MC_2;
                    end
                end
                I_LD_HL_N, I_LD_RR: begin
                    if (mcycle == MC_1) begin
                        // Low byte or immediate into Z
                        bus_op         = BUS_READ;
                        rf_ctrl.wr_en  = 1'b1;
                        rf_ctrl.wr_sel = R_Z;
                        rf_ctrl.wr_src = WR_FROM_BUS;
                        mcycle_next    = MC_2;
                    end else if (mcycle == MC_2) begin
                        mcycle_next = MC_3;
                        if (cls == I_LD_RR) begin
                            bus_op            = BUS_READ;
                            rf_ctrl.rr_load_z = 1'b1;
                            rf_ctrl.rr_sel    = rr_t'(opcode[5:4]);
                        end else begin
                            bus_op           = BUS_WRITE;
                            rf_ctrl.rd_sel   = R_Z;
                            rf_ctrl.addr_sel = ADDR_HL;
                            rf_ctrl.idu_en   = 1'b0;
                        end
                    end
                end
                I_INCDEC_RR: begin
                    if (mcycle == MC_1) begin
                        bus_op            = BUS_IDLE;
                        rf_ctrl.idu_on_pc = 1'b0;
                        rf_ctrl.idu_dec   = opcode[3];
                        rf_ctrl.rr_sel    = rr_t'(opcode[5:4]);
                        mcycle_next       = MC_2;
                    end
                end
                I_ALU_R, I_ALU_HL, I_ALU_N: begin
                    if (cls != I_ALU_R && mcycle == MC_1) begin
                        bus_op         = BUS_READ;
                        rf_ctrl.wr_en  = 1'b1;
                        rf_ctrl.wr_sel = R_Z;
                        rf_ctrl.wr_src = WR_FROM_BUS;
                        mcycle_next    = MC_2;
                        if (cls == I_ALU_HL) begin
                            rf_ctrl.addr_sel = ADDR_HL;
                            rf_ctrl.idu_en   = 1'b0;
                        end
                    end else begin
                        alu_ctrl       = '{en: 1'b1, op: grp_op, src_a: SRC_A_ACC,
                                           src_b: SRC_B_REG};
                        rf_ctrl.rd_sel = (cls == I_ALU_R) ? src : R_Z;
                        // CP only sets carry
                        rf_ctrl.wr_en  = (grp_op != CP);
                        rf_ctrl.wr_sel = R_A;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            opcode <= 8'h00;
            mcycle <= MC_1;
        end else begin
            mcycle <= mcycle_next;
            if (bus_op == BUS_FETCH)
                opcode <= mem_rdata;
        end
    end

    a_no_write_in_reset: assert property (@(posedge clk) rst |-> bus_op != BUS_WRITE);

    // Third M-cycle only for the two 3-cycle forms, always after MC_2
    a_mc3_forms: assert property (@(posedge clk) disable iff (rst)
        mcycle == MC_3 |-> (cls inside {I_LD_RR, I_LD_HL_N}) && $past(mcycle) == MC_2);

endmodule

//--- sm83_regfile.sv
`timescale 1ns/10ps

module sm83_regfile #(
    parameter sm83_pkg::addr_t RESET_VECTOR = 16'h0000
) (
    input  logic                clk,
    input  logic                rst,
    input  sm83_pkg::rf_ctrl_t  rf_ctrl,
    input  sm83_pkg::byte_t     mem_rdata,
    input  sm83_pkg::byte_t     alu_result,
    output sm83_pkg::byte_t     acc,
    output sm83_pkg::byte_t     rd_val,
    output sm83_pkg::addr_t     addr
);
    import sm83_pkg::*;

    byte_t a, b, c, d, e, h, l;
    byte_t z;
    addr_t sp;
    addr_t pc;
    byte_t wr_data;
    addr_t pair_val;
    addr_t idu_in;
    addr_t idu_out;
    logic  wr_in_pair;

    assign wr_data = (rf_ctrl.wr_src == WR_FROM_BUS) ? mem_rdata : alu_result;
    assign acc     = a;
    assign addr    = (rf_ctrl.addr_sel == ADDR_HL) ? {h, l} : pc;

    always_comb begin
        case (rf_ctrl.rd_sel)
            R_B:     rd_val = b;
            R_C:     rd_val = c;
            R_D:     rd_val = d;
            R_E:     rd_val = e;
            R_H:     rd_val = h;
            R_L:     rd_val = l;
            R_Z:     rd_val = z;
            default: rd_val = a;
        endcase
    end

    // Increment/decrement unit, wraps at 16 bits
    always_comb begin
        case (rf_ctrl.rr_sel)
            RR_BC:   pair_val = {b, c};
            RR_DE:   pair_val = {d, e};
            RR_HL:   pair_val = {h, l};
            default: pair_val = sp;
        endcase
        idu_in  = rf_ctrl.idu_on_pc ? pc : pair_val;
        idu_out = rf_ctrl.idu_dec ? idu_in - 16'd1 : idu_in + 16'd1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            {a, b, c, d, e, h, l} <= '0;
            sp <= '0;
            pc <= RESET_VECTOR;
        end else begin
            if (rf_ctrl.wr_en) begin
                case (rf_ctrl.wr_sel)
                    R_A: a <= wr_data;
                    R_B: b <= wr_data;
                    R_C: c <= wr_data;
                    R_D: d <= wr_data;
                    R_E: e <= wr_data;
                    R_H: h <= wr_data;
                    R_L: l <= wr_data;
                    default: ;
                endcase
            end
            if (rf_ctrl.rr_load_z) begin
                case (rf_ctrl.rr_sel)
                    RR_BC:   {b, c} <= {mem_rdata, z};
                    RR_DE:   {d, e} <= {mem_rdata, z};
                    RR_HL:   {h, l} <= {mem_rdata, z};
                    default: sp <= {mem_rdata, z};
                endcase
            end
            if (rf_ctrl.idu_en) begin
                if (rf_ctrl.idu_on_pc) begin
                    pc <= idu_out;
                end else begin
                    case (rf_ctrl.rr_sel)
                        RR_BC:   {b, c} <= idu_out;
                        RR_DE:   {d, e} <= idu_out;
                        RR_HL:   {h, l} <= idu_out;
                        default: sp <= idu_out;
                    endcase
                end
            end
        end
    end

    // Temporary for immediates and [HL] operands
    always_ff @(posedge clk) begin
        if (rf_ctrl.wr_en && rf_ctrl.wr_sel == R_Z)
            z <= wr_data;
    end

    always_comb begin
        case (rf_ctrl.rr_sel)
            RR_BC:   wr_in_pair = rf_ctrl.wr_sel inside {R_B, R_C};
            RR_DE:   wr_in_pair = rf_ctrl.wr_sel inside {R_D, R_E};
            RR_HL:   wr_in_pair = rf_ctrl.wr_sel inside {R_H, R_L};
            default: wr_in_pair = 1'b0;
        endcase
    end

    a_no_pair_clash: assert property (@(posedge clk) disable iff (rst)
        rf_ctrl.wr_en && rf_ctrl.rr_load_z |-> !wr_in_pair);

endmodule

//--- sm83_alu.sv
`timescale 1ns/10ps

module sm83_alu (
    input  logic                 clk,
    input  logic                 rst,
    input  sm83_pkg::alu_ctrl_t  alu_ctrl,
    input  sm83_pkg::byte_t      acc,
    input  sm83_pkg::byte_t      rd_val,
    output sm83_pkg::byte_t      result
);
    import sm83_pkg::*;

    byte_t      op_a;
    byte_t      op_b;
    logic       carry;
    logic       carry_in;
    logic [8:0] sum;
    logic [8:0] diff;

    always_comb begin
        op_a     = (alu_ctrl.src_a == SRC_A_ACC) ? acc : rd_val;
        op_b     = (alu_ctrl.src_b == SRC_B_REG) ? rd_val : 8'd1;
        carry_in = (alu_ctrl.op == ADC || alu_ctrl.op == SBC) ? carry : 1'b0;
        sum      = {1'b0, op_a} + {1'b0, op_b} + {8'd0, carry_in};
        // Bit 8 of the difference is the borrow
        diff     = {1'b0, op_a} - {1'b0, op_b} - {8'd0, carry_in};
    end

    always_comb begin
        case (alu_ctrl.op)
            ADD, ADC, INC:     result = sum[7:0];
            SUB, SBC, CP, DEC: result = diff[7:0];
            AND:               result = op_a & op_b;
            XOR:               result = op_a ^ op_b;
            OR:                result = op_a | op_b;
            default:           result = op_a;
        endcase
    end

    // Only C survives from the flag register
    always_ff @(posedge clk) begin
        if (rst) begin
            carry <= 1'b0;
        end else if (alu_ctrl.en) begin
            case (alu_ctrl.op)
                ADD, ADC:     carry <= sum[8];
                SUB, SBC, CP: carry <= diff[8];
                AND, XOR, OR: carry <= 1'b0;
                default:      carry <= carry;
            endcase
        end
    end

    a_op_defined: assert property (@(posedge clk) disable iff (rst)
        alu_ctrl.en |-> alu_ctrl.op inside {ADD, ADC, SUB, SBC, AND, XOR, OR, CP,
                                            INC, DEC, PASS});

endmodule

//--- sm83_core.sv
`timescale 1ns/10ps

module sm83_core #(
    parameter sm83_pkg::addr_t RESET_VECTOR = 16'h0000
) (
    input  logic                clk,
    input  logic                rst,
    output sm83_pkg::bus_req_t  bus_req,
    input  sm83_pkg::byte_t     mem_rdata
);
    import sm83_pkg::*;

    rf_ctrl_t  rf_ctrl;
    alu_ctrl_t alu_ctrl;
    bus_op_t   bus_op;
    byte_t     acc;
    byte_t     rd_val;
    byte_t     alu_result;
    addr_t     addr;

    // Store data is always the register-file read port
    assign bus_req = '{op: bus_op, addr: addr, wdata: rd_val};

    sm83_control i_control (
        .clk       (clk),
        .rst       (rst),
        .mem_rdata (mem_rdata),
        .rf_ctrl   (rf_ctrl),
        .alu_ctrl  (alu_ctrl),
        .bus_op    (bus_op)
    );

    sm83_regfile #(
        .RESET_VECTOR (RESET_VECTOR)
    ) i_regfile (
        .clk        (clk),
        .rst        (rst),
        .rf_ctrl    (rf_ctrl),
        .mem_rdata  (mem_rdata),
        .alu_result (alu_result),
        .acc        (acc),
        .rd_val     (rd_val),
        .addr       (addr)
    );

    sm83_alu i_alu (
        .clk      (clk),
        .rst      (rst),
        .alu_ctrl (alu_ctrl),
        .acc      (acc),
        .rd_val   (rd_val),
        .result   (alu_result)
    );

endmodule

//--- sm83_core_tb.sv
`timescale 1ns/10ps

module sm83_core_tb;
    import sm83_pkg::*;

    localparam addr_t      RESET_VECTOR = 16'h0100;
    localparam int         TIMEOUT      = 2000;
    localparam logic [2:0] REG_B        = 3'd0;
    localparam logic [2:0] REG_C        = 3'd1;
    localparam logic [2:0] REG_D        = 3'd2;
    localparam logic [2:0] REG_E        = 3'd3;
    localparam logic [2:0] REG_A        = 3'd7;
    localparam logic [1:0] PAIR_BC      = 2'd0;
    localparam logic [1:0] PAIR_DE      = 2'd1;
    localparam logic [1:0] PAIR_HL      = 2'd2;
    localparam logic [1:0] PAIR_SP      = 2'd3;

    logic     clk;
    logic     rst;
    bus_req_t bus_req;
    byte_t    mem_rdata;

    byte_t mem [0:65535];
    byte_t image [0:65535];
    byte_t written [addr_t];
    // Reference state of the core while the program is built
    byte_t regs [0:7];
    logic  carry_m;
    addr_t sp_m;
    addr_t pc_b;
    addr_t instr_addr [$];
    int    instr_len [$];
    addr_t store_addr [$];
    byte_t store_val [$];
    int    fetch_idx     = 0;
    int    store_idx     = 0;
    int    since_fetch   = 0;
    int    reset_errors  = 0;
    int    fetch_errors  = 0;
    int    length_errors = 0;
    int    store_errors  = 0;

    sm83_core #(
        .RESET_VECTOR (RESET_VECTOR)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .bus_req   (bus_req),
        .mem_rdata (mem_rdata)
    );

    // Image loads during reset, stores land on the rising edge
    assign mem_rdata = mem[bus_req.addr];

    always @(posedge clk) begin
        if (rst)
            mem <= image;
        else if (bus_req.op == BUS_WRITE)
            mem[bus_req.addr] <= bus_req.wdata;
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    a_idle_in_reset: assert property (@(posedge clk) rst |-> bus_req.op == BUS_IDLE)
        else begin
            reset_errors++;
            $display("error at %0t: bus_req.op in reset expected %0d, got %0d",
                     $time, BUS_IDLE, $sampled(bus_req.op));
        end

    a_first_fetch: assert property (@(posedge clk)
        $fell(rst) |-> bus_req.op == BUS_FETCH && bus_req.addr == RESET_VECTOR)
        else begin
            reset_errors++;
            $display("error at %0t: bus_req.addr first fetch expected %h, got %h (op %0d)",
                     $time, RESET_VECTOR, $sampled(bus_req.addr), $sampled(bus_req.op));
        end

    // Mid-cycle monitor for fetch order, instruction lengths and stores
    always @(negedge clk) begin
        if (rst) begin
            since_fetch = 0;
        end else begin
            since_fetch++;
            if (bus_req.op == BUS_FETCH) begin
                if (fetch_idx < instr_addr.size()) begin
                    assert (bus_req.addr == instr_addr[fetch_idx]) else begin
                        fetch_errors++;
                        $display("error at %0t: bus_req.addr fetch %0d expected %h, got %h",
                                 $time, fetch_idx, instr_addr[fetch_idx], bus_req.addr);
                    end
                end
                if (fetch_idx > 0 && fetch_idx <= instr_len.size()) begin
                    assert (since_fetch == instr_len[fetch_idx - 1]) else begin
                        length_errors++;
                        $display("error at %0t: cycles of instr %0d expected %0d, got %0d",
                                 $time, fetch_idx - 1, instr_len[fetch_idx - 1], since_fetch);
                    end
                end
                fetch_idx++;
                since_fetch = 0;
            end
            if (bus_req.op == BUS_WRITE) begin
                if (store_idx < store_addr.size()) begin
                    assert (bus_req.addr == store_addr[store_idx]) else begin
                        store_errors++;
                        $display("error at %0t: bus_req.addr store %0d expected %h, got %h",
                                 $time, store_idx, store_addr[store_idx], bus_req.addr);
                    end
                    assert (bus_req.wdata == store_val[store_idx]) else begin
                        store_errors++;
                        $display("error at %0t: bus_req.wdata store %0d expected %h, got %h",
                                 $time, store_idx, store_val[store_idx], bus_req.wdata);
                    end
                end else begin
                    store_errors++;
                    $display("unexpected bus write at %0t to address %h", $time, bus_req.addr);
                end
                store_idx++;
            end
        end
    end

    function automatic byte_t rnd();
        return byte_t'($urandom);
    endfunction

    function automatic addr_t pair_get(input logic [1:0] rr);
        if (rr == PAIR_SP)
            return sp_m;
        else
            return {regs[{rr, 1'b0}], regs[{rr, 1'b1}]};
    endfunction

    task automatic pair_set(input logic [1:0] rr, input addr_t value);
        if (rr == PAIR_SP) begin
            sp_m = value;
        end else begin
            regs[{rr, 1'b0}] = value[15:8];
            regs[{rr, 1'b1}] = value[7:0];
        end
    endtask

    function automatic byte_t mem_at_hl();
        addr_t hl;
        hl = pair_get(PAIR_HL);
        return written.exists(hl) ? written[hl] : image[hl];
    endfunction

    task automatic begin_instr(input int cycles);
        instr_addr.push_back(pc_b);
        instr_len.push_back(cycles);
    endtask

    task automatic emit(input byte_t value);
        image[pc_b] = value;
        pc_b = pc_b + 16'd1;
    endtask

    task automatic expect_store(input byte_t value);
        addr_t hl;
        hl = pair_get(PAIR_HL);
        store_addr.push_back(hl);
        store_val.push_back(value);
        written[hl] = value;
    endtask

    task automatic ld_rr_nn(input logic [1:0] rr, input addr_t nn);
        begin_instr(3);
        emit({2'b00, rr, 4'b0001});
        emit(nn[7:0]);
        emit(nn[15:8]);
        pair_set(rr, nn);
    endtask

    task automatic ld_r_n(input logic [2:0] r, input byte_t n);
        begin_instr(2);
        emit({2'b00, r, 3'b110});
        emit(n);
        regs[r] = n;
    endtask

    task automatic ld_r_r(input logic [2:0] dst, input logic [2:0] src);
        begin_instr(1);
        emit({2'b01, dst, src});
        regs[dst] = regs[src];
    endtask

    task automatic ld_r_hl(input logic [2:0] r);
        begin_instr(2);
        emit({2'b01, r, 3'b110});
        regs[r] = mem_at_hl();
    endtask

    task automatic st_hl_r(input logic [2:0] r);
        begin_instr(2);
        emit({5'b01110, r});
        expect_store(regs[r]);
    endtask

    task automatic st_hl_n(input byte_t n);
        begin_instr(3);
        emit(8'h36);
        emit(n);
        expect_store(n);
    endtask

    task automatic incdec_r(input logic [2:0] r, input logic dec);
        begin_instr(1);
        emit({2'b00, r, 2'b10, dec});
        regs[r] = dec ? regs[r] - 8'd1 : regs[r] + 8'd1;
    endtask

    task automatic incdec_rr(input logic [1:0] rr, input logic dec);
        begin_instr(2);
        emit({2'b00, rr, dec, 3'b011});
        pair_set(rr, dec ? pair_get(rr) - 16'd1 : pair_get(rr) + 16'd1);
    endtask

    task automatic store_and_step(input logic [2:0] r);
        st_hl_r(r);
        incdec_rr(PAIR_HL, 1'b0);
    endtask

    // Mode 0 register, 1 [HL], 2 immediate
    task automatic alu(input alu_op_t op, input logic [1:0] mode, input logic [2:0] r);
        byte_t operand;
        byte_t n;
        int    full;
        logic  cin;
        n = rnd();
        case (mode)
            2'd0: begin
                begin_instr(1);
                emit({2'b10, op[2:0], r});
                operand = regs[r];
            end
            2'd1: begin
                begin_instr(2);
                emit({2'b10, op[2:0], 3'b110});
                operand = mem_at_hl();
            end
            default: begin
                begin_instr(2);
                emit({2'b11, op[2:0], 3'b110});
                emit(n);
                operand = n;
            end
        endcase
        cin = (op == ADC || op == SBC) && carry_m;
        case (op)
            ADD, ADC: begin
                full    = int'(regs[REG_A]) + int'(operand) + int'(cin);
                carry_m = full > 255;
            end
            SUB, SBC, CP: begin
                full    = int'(regs[REG_A]) - int'(operand) - int'(cin);
                carry_m = full < 0;
            end
            AND: begin
                full    = int'(regs[REG_A] & operand);
                carry_m = 1'b0;
            end
            XOR: begin
                full    = int'(regs[REG_A] ^ operand);
                carry_m = 1'b0;
            end
            default: begin
                full    = int'(regs[REG_A] | operand);
                carry_m = 1'b0;
            end
        endcase
        if (op != CP)
            regs[REG_A] = byte_t'(full);
    endtask

    task automatic build_program();
        for (int i = 0; i < 65536; i++)
            image[i[15:0]] = i[7:0] ^ {i[11:8], i[15:12]} ^ 8'h5a;
        for (int i = 0; i < 8; i++)
            regs[i] = 8'h00;
        carry_m = 1'b0;
        sp_m    = 16'h0000;
        pc_b    = RESET_VECTOR;

        ld_rr_nn(PAIR_HL, {8'hc0, rnd()});
        ld_r_n(REG_B, rnd());
        ld_r_n(REG_C, rnd());
        ld_r_n(REG_D, rnd());
        ld_r_n(REG_E, rnd());
        ld_r_n(REG_A, rnd());
        store_and_step(REG_B);
        ld_r_r(REG_D, REG_E);
        store_and_step(REG_D);
        ld_r_r(REG_E, REG_A);
        store_and_step(REG_E);
        st_hl_n(rnd());
        ld_r_hl(REG_B);
        incdec_rr(PAIR_HL, 1'b0);
        store_and_step(REG_B);

        // Every ALU op with each operand kind, carry chained through ADC and SBC
        for (int m = 0; m < 3; m++) begin
            for (int op = 0; op < 8; op++) begin
                ld_r_n(REG_A, rnd());
                alu(alu_op_t'(op[3:0]), m[1:0], REG_C);
                store_and_step(REG_A);
            end
        end

        // Carry survives INC and DEC, which wrap at 8 bits
        ld_r_n(REG_A, 8'h00);
        ld_r_n(REG_C, 8'h01);
        alu(SUB, 2'd0, REG_C);
        incdec_r(REG_A, 1'b0);
        // No carry out here while carry is set
        incdec_r(REG_C, 1'b0);
        store_and_step(REG_A);
        ld_r_n(REG_B, 8'h00);
        alu(ADC, 2'd0, REG_B);
        store_and_step(REG_A);
        // Borrow out here while carry is clear
        ld_r_n(REG_D, 8'h00);
        incdec_r(REG_D, 1'b1);
        alu(SBC, 2'd0, REG_B);
        store_and_step(REG_A);
        store_and_step(REG_D);
        ld_r_n(REG_A, 8'h00);
        alu(CP, 2'd0, REG_C);
        alu(SBC, 2'd0, REG_B);
        store_and_step(REG_A);

        // HL wraps at 16 bits
        ld_rr_nn(PAIR_HL, 16'hffff);
        incdec_rr(PAIR_HL, 1'b0);
        st_hl_r(REG_D);
        incdec_rr(PAIR_HL, 1'b1);
        st_hl_r(REG_E);

        ld_rr_nn(PAIR_BC, {rnd(), rnd()});
        ld_rr_nn(PAIR_DE, {rnd(), rnd()});
        ld_rr_nn(PAIR_SP, {rnd(), rnd()});
        incdec_rr(PAIR_SP, 1'b0);
        incdec_rr(PAIR_BC, 1'b1);
        ld_rr_nn(PAIR_HL, 16'hd000);
        store_and_step(REG_B);
        store_and_step(REG_C);
        store_and_step(REG_D);
        store_and_step(REG_E);

        // PUSH BC and HALT run as NOP, then a NOP tail
        begin_instr(1);
        emit(8'hc5);
        begin_instr(1);
        emit(8'h76);
        for (int i = 0; i < 3; i++) begin
            begin_instr(1);
            emit(8'h00);
        end
    endtask

    initial begin
        int waited;
        rst = 1'b1;
        void'($urandom(32'h2eb75d3a));
        build_program();
        repeat (2) @(posedge clk);
        #5 rst = 1'b0;

        waited = 0;
        while (fetch_idx < instr_addr.size() && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end

        if (fetch_idx < instr_addr.size()) begin
            $display("timeout after %0d cycles with %0d of %0d instructions fetched",
                     waited, fetch_idx, instr_addr.size());
            $display("errors: reset %0d, fetch %0d, length %0d, store %0d",
                     reset_errors, fetch_errors, length_errors, store_errors);
            $display("Regression failed");
            $finish;
        end else begin
            if (store_idx != store_addr.size()) begin
                store_errors++;
                $display("only %0d of %0d expected stores were seen",
                         store_idx, store_addr.size());
            end
            $display("errors: reset %0d, fetch %0d, length %0d, store %0d",
                     reset_errors, fetch_errors, length_errors, store_errors);
            if (reset_errors + fetch_errors + length_errors + store_errors == 0)
                $display("Regression passed");
            else
                $display("Regression failed");
            $finish;
        end
    end

endmodule

//--- sm83_core.f
sm83_pkg.sv
sm83_control.sv
sm83_regfile.sv
sm83_alu.sv
sm83_core.sv
sm83_core_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = sm83_core_tb
FILELIST = sm83_core.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# The log decides the result, a missing end message also counts as failure
run: build
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
